// ==== Makefile ====
# Verilator flow for the AHB to APB bridge testbench

TOOL       = verilator
FLAGS      = --timing --assert
LINT_FLAGS = --lint-only $(FLAGS)
TOP        = tb_ahb2apb
FILELIST   = vlog.f
OBJ_DIR    = obj_dir
LOG        = sim.log
PASS_MSG   = Test completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== src/ahb2apb_bridge.sv ====
/* AHB-Lite to APB bridge top with two APB slave ports. PCLKEN paces the
   APB side from HCLK, PORT_SEL_BIT or addr_switch picks the port. */
`timescale 1ns/1ps

module ahb2apb_bridge #(
  parameter int ADDR_WIDTH   = 32,
  parameter int PORT_SEL_BIT = 22
) (
  input  logic                        HCLK,
  input  logic                        HRESETn,
  input  logic                        PCLKEN,       // APB clock enable
  // AHB-Lite slave
  input  logic                        HSEL,
  input  logic [ADDR_WIDTH-1:0]       HADDR,
  input  logic [1:0]                  HTRANS,
  input  ahb_pkg::hsize_t             HSIZE,
  input  logic [3:0]                  HPROT,
  input  logic                        HWRITE,
  input  logic                        HREADY,
  input  logic [ahb_pkg::DATA_W-1:0]  HWDATA,
  output logic                        HREADYOUT,
  output logic                        HRESP,
  output logic [ahb_pkg::DATA_W-1:0]  HRDATA,
  input  logic                        addr_switch,  // Force port 1
  // APB port 0
  output logic [ADDR_WIDTH-1:0]       PADDR_0,
  output logic                        PSEL_0,
  output logic                        PENABLE_0,
  output logic                        PWRITE_0,
  output logic [apb_pkg::STRB_W-1:0]  PSTRB_0,
  output logic [apb_pkg::PPROT_W-1:0] PPROT_0,
  output logic [ahb_pkg::DATA_W-1:0]  PWDATA_0,
  input  logic [ahb_pkg::DATA_W-1:0]  PRDATA_0,
  input  logic                        PREADY_0,
  input  logic                        PSLVERR_0,
  // APB port 1
  output logic [ADDR_WIDTH-1:0]       PADDR_1,
  output logic                        PSEL_1,
  output logic                        PENABLE_1,
  output logic                        PWRITE_1,
  output logic [apb_pkg::STRB_W-1:0]  PSTRB_1,
  output logic [apb_pkg::PPROT_W-1:0] PPROT_1,
  output logic [ahb_pkg::DATA_W-1:0]  PWDATA_1,
  input  logic [ahb_pkg::DATA_W-1:0]  PRDATA_1,
  input  logic                        PREADY_1,
  input  logic                        PSLVERR_1
);

  logic done;  // APB access ends this cycle
  logic busy;  // Request in flight on APB

  apb_req_if #(.ADDR_WIDTH(ADDR_WIDTH)) u_req ();
  apb_bus_if #(.ADDR_WIDTH(ADDR_WIDTH)) u_bus ();

  // --------------------
  // Datapath stages
  // --------------------
  ahb_decode #(.ADDR_WIDTH(ADDR_WIDTH)) u_decode (
    .req (u_req),
    .*
  );

  apb_execute #(.ADDR_WIDTH(ADDR_WIDTH)) u_execute (
    .req (u_req),
    .bus (u_bus),
    .*
  );

  ahb_result u_result (
    .bus (u_bus),
    .*
  );

  // Two port fan-out
  apb_port_steer #(
    .ADDR_WIDTH   (ADDR_WIDTH),
    .PORT_SEL_BIT (PORT_SEL_BIT)
  ) u_steer (
    .bus (u_bus),
    .*
  );

endmodule

// ==== src/ahb_decode.sv ====
/* AHB address phase decode. Qualifies a transfer, builds byte strobes and
   PPROT, and registers the request for the APB sequencer. */
`timescale 1ns/1ps

module ahb_decode #(
  parameter int ADDR_WIDTH = 32
) (
  input  logic                  HCLK,
  input  logic                  HRESETn,
  input  logic                  HSEL,
  input  logic                  HWRITE,
  input  logic                  HREADY,
  input  logic [ADDR_WIDTH-1:0] HADDR,
  input  logic [1:0]            HTRANS,
  input  ahb_pkg::hsize_t       HSIZE,
  input  logic [3:0]            HPROT,
  apb_req_if.source             req
);

  logic                        accept;    // Address phase taken this cycle
  logic [apb_pkg::STRB_W-1:0]  strb_nxt;
  logic [apb_pkg::PPROT_W-1:0] prot_nxt;

  assign accept = HSEL & HTRANS[ahb_pkg::HTRANS_SEQ_BIT] & HREADY;

  // --------------------
  // Byte lanes
  // --------------------
  always_comb
  begin
    case (HSIZE)
      ahb_pkg::hsize_byte: strb_nxt = 4'b0001 << HADDR[1:0];      // Single lane
      ahb_pkg::hsize_half: strb_nxt = HADDR[1] ? 4'b1100 : 4'b0011;
      default:             strb_nxt = '1;                         // Full word
    endcase
    if (!HWRITE)
      strb_nxt = '0;  // No strobes on reads
  end

  // AHB protection to APB protection
  always_comb
  begin
    prot_nxt                           = '0;
    prot_nxt[apb_pkg::PPROT_PRIV_BIT]  = HPROT[ahb_pkg::HPROT_PRIV_BIT];
    prot_nxt[apb_pkg::PPROT_NSEC_BIT]  = 1'b0;
    prot_nxt[apb_pkg::PPROT_INSTR_BIT] = ~HPROT[ahb_pkg::HPROT_DATA_BIT];
  end

  // --------------------
  // Request registers
  // --------------------
  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
      req.start <= 1'b0;
    else
      req.start <= accept;  // Pulse one cycle after the address phase
  end

  // Fields held until the next accepted transfer
  always_ff @(posedge HCLK)
  begin
    if (accept)
    begin
      req.addr  <= HADDR[ADDR_WIDTH-1:apb_pkg::WORD_LSB];
      req.write <= HWRITE;
      req.strb  <= strb_nxt;
      req.prot  <= prot_nxt;
    end
  end

endmodule

// ==== src/ahb_pkg.sv ====
/* AHB-Lite constants for the bridge front end and response logic.
   Modules refer to these with ahb_pkg:: scoping. */

package ahb_pkg;

  // --------------------
  // Data path
  // --------------------
  parameter int DATA_W = 32;  // HWDATA and HRDATA width

  // --------------------
  // Control fields
  // --------------------

  // HTRANS[1] set means NONSEQ or SEQ
  parameter int HTRANS_SEQ_BIT = 1;

  // HPROT bit positions
  parameter int HPROT_DATA_BIT = 0;  // High for data, low for opcode fetch
  parameter int HPROT_PRIV_BIT = 1;  // High for privileged access

  // Transfer size, only up to the bus width
  typedef enum logic [2:0] {
    hsize_byte = 3'b000,  // 8 bit
    hsize_half = 3'b001,  // 16 bit
    hsize_word = 3'b010   // 32 bit
  } hsize_t;

endpackage

// ==== src/ahb_result.sv ====
/* AHB response stage. Registers APB read data and turns the APB result
   into an OKAY cycle or the two cycle AHB error response. */
`timescale 1ns/1ps

module ahb_result (
  input  logic                       HCLK,
  input  logic                       HRESETn,
  input  logic                       done,
  input  logic                       busy,
  apb_bus_if.monitor                 bus,
  output logic                       HREADYOUT,
  output logic                       HRESP,
  output logic [ahb_pkg::DATA_W-1:0] HRDATA
);

  logic err1_q;  // First error cycle, ready low
  logic err2_q;  // Second error cycle, ready high

  // --------------------
  // Error sequence
  // --------------------
  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      err1_q <= 1'b0;
      err2_q <= 1'b0;
    end
    else
    begin
      err1_q <= done & bus.pslverr;
      err2_q <= err1_q;
    end
  end

  // Read data for the completion cycle
  always_ff @(posedge HCLK)
  begin
    if (done)
      HRDATA <= bus.prdata;
  end

  assign HREADYOUT = ~(busy | err1_q);  // Stall during APB and first error cycle
  assign HRESP     = err1_q | err2_q;

  // First error cycle always followed by the second, with ready back high
  a_err_two_cycles: assert property (@(posedge HCLK) disable iff (!HRESETn)
    (HRESP && !HREADYOUT) |=> (HRESP && HREADYOUT));

  // Ready with error only right after the first error cycle
  a_err_ready_only_second: assert property (@(posedge HCLK) disable iff (!HRESETn)
    (HRESP && HREADYOUT) |-> $past(HRESP && !HREADYOUT));

endmodule

// ==== src/apb_execute.sv ====
/* APB setup and access sequencer. Runs one APB transfer per request,
   stepping only on PCLKEN and holding access while PREADY is low. */
`timescale 1ns/1ps

module apb_execute #(
  parameter int ADDR_WIDTH = 32
) (
  input  logic                       HCLK,
  input  logic                       HRESETn,
  input  logic                       PCLKEN,
  input  logic [ahb_pkg::DATA_W-1:0] HWDATA,
  apb_req_if.sink                    req,
  apb_bus_if.master                  bus,
  output logic                       done,
  output logic                       busy
);

  apb_pkg::exec_state_t state_q;    // Registered state
  apb_pkg::exec_state_t state_cur;  // State seen this cycle
  apb_pkg::exec_state_t state_nxt;
  logic                 pclken_q;   // PCLKEN in the previous cycle

  // --------------------
  // State decode
  // --------------------

  // The start cycle already acts as setup when PCLKEN was high in the
  // accepting cycle, which saves a cycle on the AHB side
  always_comb
  begin
    state_cur = state_q;
    if (state_q == apb_pkg::exec_idle && req.start)
      state_cur = pclken_q ? apb_pkg::exec_setup : apb_pkg::exec_wait_pclk;
  end

  assign done = (state_cur == apb_pkg::exec_access) & bus.pready & PCLKEN;
  assign busy = (state_q != apb_pkg::exec_idle) | req.start;

  always_comb
  begin
    state_nxt = state_cur;
    case (state_cur)
      apb_pkg::exec_wait_pclk:
      begin
        if (PCLKEN)
          state_nxt = apb_pkg::exec_setup;   // APB edge reached
      end
      apb_pkg::exec_setup:
      begin
        if (PCLKEN)
          state_nxt = apb_pkg::exec_access;
      end
      apb_pkg::exec_access:
      begin
        if (done)
          state_nxt = apb_pkg::exec_idle;    // Response stage completes AHB
      end
      default:
        state_nxt = apb_pkg::exec_idle;
    endcase
  end

  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      state_q  <= apb_pkg::exec_idle;
      pclken_q <= 1'b0;
    end
    else
    begin
      state_q  <= state_nxt;
      pclken_q <= PCLKEN;
    end
  end

  // --------------------
  // APB bus outputs
  // --------------------
  assign bus.psel    = (state_cur == apb_pkg::exec_setup) |
                       (state_cur == apb_pkg::exec_access);
  assign bus.penable = (state_cur == apb_pkg::exec_access);
  assign bus.paddr   = ADDR_WIDTH'({req.addr, {apb_pkg::WORD_LSB{1'b0}}});
  assign bus.pwrite  = req.write;
  assign bus.pstrb   = req.strb;
  assign bus.pprot   = req.prot;
  assign bus.pwdata  = HWDATA;  // Data phase value, stable while stalled

  // Every access cycle sits in an APB transfer that began with a setup cycle
  a_enable_after_setup: assert property (@(posedge HCLK) disable iff (!HRESETn)
    bus.penable |-> (bus.psel && $past(bus.psel)));

  // PSEL drops in the cycle after done, no new request overlaps it
  a_psel_drops_after_done: assert property (@(posedge HCLK) disable iff (!HRESETn)
    done |=> !bus.psel);

endmodule

// ==== src/apb_if.sv ====
/* Internal bridge interfaces. apb_req_if carries a captured request to the
   APB sequencer, apb_bus_if is the single internal APB bus before steering. */
`timescale 1ns/1ps

// Request from the AHB decode stage
interface apb_req_if #(
  parameter int ADDR_WIDTH = 32
);
  logic                                   start;  // One cycle per request
  logic [ADDR_WIDTH-apb_pkg::WORD_LSB-1:0] addr;  // Word address
  logic                                   write;
  logic [apb_pkg::STRB_W-1:0]             strb;
  logic [apb_pkg::PPROT_W-1:0]            prot;

  modport source (output start, addr, write, strb, prot);
  modport sink   (input  start, addr, write, strb, prot);
endinterface

// Internal APB bus
interface apb_bus_if #(
  parameter int ADDR_WIDTH = 32
);
  logic [ADDR_WIDTH-1:0]       paddr;
  logic                        psel;
  logic                        penable;
  logic                        pwrite;
  logic [apb_pkg::STRB_W-1:0]  pstrb;
  logic [apb_pkg::PPROT_W-1:0] pprot;
  logic [ahb_pkg::DATA_W-1:0]  pwdata;
  logic [ahb_pkg::DATA_W-1:0]  prdata;   // From the selected port
  logic                        pready;
  logic                        pslverr;

  modport master  (output paddr, psel, penable, pwrite, pstrb, pprot, pwdata,
                   input  prdata, pready, pslverr);
  modport slave   (input  paddr, psel, penable, pwrite, pstrb, pprot, pwdata,
                   output prdata, pready, pslverr);
  modport monitor (input  prdata, pslverr);  // Response capture only
endinterface

// ==== src/apb_pkg.sv ====
/* APB side widths, PPROT bit layout and the execute FSM state type.
   Used by decode, execute, port steering and the interfaces. */

package apb_pkg;

  // --------------------
  // Bus field widths
  // --------------------
  parameter int STRB_W   = 4;  // One strobe per byte lane
  parameter int PPROT_W  = 3;
  parameter int WORD_LSB = 2;  // Byte offset bits not kept in the request

  // --------------------
  // PPROT layout
  // --------------------
  parameter int PPROT_PRIV_BIT  = 0;  // Privileged
  parameter int PPROT_NSEC_BIT  = 1;  // Non-secure, always driven low here
  parameter int PPROT_INSTR_BIT = 2;  // Instruction fetch

  // --------------------
  // Execute FSM
  // --------------------

  // wait_pclk holds a request until PCLKEN allows setup
  typedef enum logic [1:0] {
    exec_idle      = 2'b00,
    exec_wait_pclk = 2'b01,
    exec_setup     = 2'b10,  // PSEL high, PENABLE low
    exec_access    = 2'b11   // PSEL and PENABLE high
  } exec_state_t;

endpackage

// ==== src/apb_port_steer.sv ====
/* Steers the internal APB bus to slave port 0 or 1 by address bit or by
   addr_switch, and returns the response of the selected port. */
`timescale 1ns/1ps

module apb_port_steer #(
  parameter int ADDR_WIDTH   = 32,
  parameter int PORT_SEL_BIT = 22
) (
  apb_bus_if.slave                    bus,
  input  logic                        addr_switch,
  output logic                        PSEL_0,
  output logic                        PSEL_1,
  output logic                        PENABLE_0,
  output logic                        PENABLE_1,
  output logic                        PWRITE_0,
  output logic                        PWRITE_1,
  output logic [ADDR_WIDTH-1:0]       PADDR_0,
  output logic [ADDR_WIDTH-1:0]       PADDR_1,
  output logic [apb_pkg::STRB_W-1:0]  PSTRB_0,
  output logic [apb_pkg::STRB_W-1:0]  PSTRB_1,
  output logic [apb_pkg::PPROT_W-1:0] PPROT_0,
  output logic [apb_pkg::PPROT_W-1:0] PPROT_1,
  output logic [ahb_pkg::DATA_W-1:0]  PWDATA_0,
  output logic [ahb_pkg::DATA_W-1:0]  PWDATA_1,
  input  logic [ahb_pkg::DATA_W-1:0]  PRDATA_0,
  input  logic [ahb_pkg::DATA_W-1:0]  PRDATA_1,
  input  logic                        PREADY_0,
  input  logic                        PREADY_1,
  input  logic                        PSLVERR_0,
  input  logic                        PSLVERR_1
);

  logic sel1;  // Port 1 chosen

  assign sel1 = bus.paddr[PORT_SEL_BIT] | addr_switch;

  // Select and write qualified per port
  assign PSEL_0   = bus.psel & ~sel1;
  assign PSEL_1   = bus.psel & sel1;
  assign PWRITE_0 = PSEL_0 & bus.pwrite;
  assign PWRITE_1 = PSEL_1 & bus.pwrite;

  // Shared request fields
  assign PENABLE_0 = bus.penable;
  assign PENABLE_1 = bus.penable;
  assign PADDR_0   = bus.paddr;
  assign PADDR_1   = bus.paddr;
  assign PSTRB_0   = bus.pstrb;
  assign PSTRB_1   = bus.pstrb;
  assign PPROT_0   = bus.pprot;
  assign PPROT_1   = bus.pprot;
  assign PWDATA_0  = bus.pwdata;
  assign PWDATA_1  = bus.pwdata;

  // --------------------
  // Response mux
  // --------------------
  assign bus.prdata  = sel1 ? PRDATA_1  : PRDATA_0;
  assign bus.pready  = sel1 ? PREADY_1  : PREADY_0;
  assign bus.pslverr = sel1 ? PSLVERR_1 : PSLVERR_0;

  // One slave port at a time
  always_comb
  begin
    a_one_port: assert (!(PSEL_0 && PSEL_1));
  end

endmodule

// ==== testbench/tb_ahb2apb.sv ====
/* Testbench for the AHB-Lite to APB bridge. Issues single AHB transfers, models
   two APB slaves and checks each transfer against a reference model. */
`timescale 1ns/1ps

module tb_ahb2apb;

  localparam int ADDR_WIDTH   = 32;
  localparam int PORT_SEL_BIT = 22;
  localparam int CLK_PERIOD   = 20;
  localparam int N_XFER       = 67;  // Sum over all test groups
  localparam int XFER_BUDGET  = 64;  // Worst case cycles per transfer

  // Expected result of one transfer
  typedef struct packed {
    logic        port;
    logic        write;
    logic [3:0]  strb;
    logic [2:0]  prot;
    logic [31:0] paddr;
    logic [31:0] wdata;
    logic [31:0] rdata;
    logic        err;
    logic        fixed;  // PCLKEN and PREADY held high
  } xfer_exp_t;

  logic                  HCLK = 1'b0;
  logic                  HRESETn;
  logic                  PCLKEN = 1'b1;
  logic                  HSEL;
  logic                  HWRITE;
  logic                  HREADY;
  logic                  addr_switch;
  logic [ADDR_WIDTH-1:0] HADDR;
  logic [1:0]            HTRANS;
  ahb_pkg::hsize_t       HSIZE;
  logic [3:0]            HPROT;
  logic [31:0]           HWDATA;
  logic [31:0]           HRDATA;
  logic                  HREADYOUT;
  logic                  HRESP;
  logic [31:0]           PADDR_0, PADDR_1;
  logic [31:0]           PWDATA_0, PWDATA_1;
  logic [31:0]           PRDATA_0 = '0;
  logic [31:0]           PRDATA_1 = '0;
  logic                  PSEL_0, PSEL_1;
  logic                  PENABLE_0, PENABLE_1;
  logic                  PWRITE_0, PWRITE_1;
  logic [3:0]            PSTRB_0, PSTRB_1;
  logic [2:0]            PPROT_0, PPROT_1;
  logic                  PREADY_0 = 1'b1;
  logic                  PREADY_1 = 1'b1;
  logic                  PSLVERR_0 = 1'b0;
  logic                  PSLVERR_1 = 1'b0;

  xfer_exp_t exp_q[$];            // Accepted transfers, in order
  int        n_checked   = 0;     // Completed by the compare process
  int        lat         = 0;     // Cycles since acceptance
  logic      err_seen    = 1'b0;  // First error cycle passed
  logic      in_access   = 1'b0;  // Setup already had PCLKEN high
  logic      prev_sel    = 1'b0;
  logic      prev_en     = 1'b0;
  logic      prev_pclken = 1'b0;
  logic      pclk_random = 1'b0;
  logic      wait_states = 1'b0;
  string     test_name   = "reset";
  int        i;

  always #(CLK_PERIOD / 2) HCLK = ~HCLK;

  assign HREADY = HREADYOUT;  // Single slave on the AHB

  ahb2apb_bridge #(
    .ADDR_WIDTH   (ADDR_WIDTH),
    .PORT_SEL_BIT (PORT_SEL_BIT)
  ) UUT (.*);

  // --------------------
  // Reference model
  // --------------------
  function automatic logic [31:0] read_pattern(input logic port, input logic [31:0] paddr);
    return {paddr[15:0], paddr[31:16]} ^ (port ? 32'hC3A5_5A3C : 32'h1234_8765);
  endfunction

  function automatic logic [31:0] rsv_addr(input logic port);
    return port ? 32'h0040_0F80 : 32'h0000_0F00;  // Slave raises PSLVERR here
  endfunction

  function automatic xfer_exp_t ref_model(input logic [31:0] addr, input logic write,
                                          input ahb_pkg::hsize_t size, input logic [3:0] hprot,
                                          input logic sw, input logic [31:0] wdata);
    xfer_exp_t e;
    int        nbytes;
    int        lo;
    int        k;
    nbytes = 1 << int'(size);
    lo     = (int'(addr[1:0]) / nbytes) * nbytes;  // First lane of the access
    e.port  = addr[PORT_SEL_BIT] | sw;
    e.write = write;
    for (k = 0; k < 4; k++)
      e.strb[k] = write && (k >= lo) && (k < lo + nbytes);
    e.prot  = {~hprot[ahb_pkg::HPROT_DATA_BIT], 1'b0, hprot[ahb_pkg::HPROT_PRIV_BIT]};
    e.paddr = {addr[31:2], 2'b00};
    e.wdata = wdata;
    e.rdata = read_pattern(e.port, e.paddr);
    e.err   = (e.paddr == rsv_addr(e.port));
    e.fixed = !pclk_random && !wait_states;
    return e;
  endfunction

  task automatic check_value(input string what, input logic [31:0] expv,
                             input logic [31:0] actv);
    if (actv !== expv)
    begin
      $display("FAILED %s %s: expected %h, actual %h", test_name, what, expv, actv);
      $display("Test failed");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  // --------------------
  // APB slaves and PCLKEN
  // --------------------
  always @(posedge HCLK)
  begin
    PRDATA_0  <= read_pattern(1'b0, PADDR_0);
    PSLVERR_0 <= (PADDR_0 == rsv_addr(1'b0));
    PREADY_0  <= wait_states ? ($urandom_range(0, 3) != 0) : 1'b1;  // Random waits
  end

  always @(posedge HCLK)
  begin
    PRDATA_1  <= read_pattern(1'b1, PADDR_1);
    PSLVERR_1 <= (PADDR_1 == rsv_addr(1'b1));
    PREADY_1  <= wait_states ? ($urandom_range(0, 3) != 0) : 1'b1;
  end

  always @(posedge HCLK)
    PCLKEN <= pclk_random ? ($urandom_range(0, 1) == 1) : 1'b1;

  // --------------------
  // Compare process
  // --------------------
  task automatic end_transfer(input xfer_exp_t e);
    if (e.fixed)
      check_value("completion cycle", e.err ? 32'd4 : 32'd3, 32'(lat));
    n_checked++;
    lat       = 0;
    err_seen  = 1'b0;
    in_access = 1'b0;
  endtask

  task automatic compare_cycle();
    xfer_exp_t e;
    e = exp_q[n_checked];
    lat++;
    if (PSEL_0 || PSEL_1)
    begin
      check_value("PSEL_0", 32'(!e.port), 32'(PSEL_0));
      check_value("PSEL_1", 32'(e.port), 32'(PSEL_1));
      check_value("PWRITE_0", 32'(!e.port && e.write), 32'(PWRITE_0));
      check_value("PWRITE_1", 32'(e.port && e.write), 32'(PWRITE_1));
      check_value("PADDR", e.paddr, e.port ? PADDR_1 : PADDR_0);
      check_value("PSTRB", 32'(e.strb), 32'(e.port ? PSTRB_1 : PSTRB_0));
      check_value("PPROT", 32'(e.prot), 32'(e.port ? PPROT_1 : PPROT_0));
      if (e.write)
        check_value("PWDATA", e.wdata, e.port ? PWDATA_1 : PWDATA_0);
      check_value("PENABLE", 32'(in_access), 32'(e.port ? PENABLE_1 : PENABLE_0));
      if (PCLKEN)
        in_access = 1'b1;  // Setup ends on an enabled cycle
    end
    if (err_seen)
    begin
      check_value("HREADYOUT in second error cycle", 32'd1, 32'(HREADYOUT));
      check_value("HRESP in second error cycle", 32'd1, 32'(HRESP));
      end_transfer(e);
    end
    else if (HRESP)
    begin
      check_value("error response", 32'(e.err), 32'd1);
      check_value("HREADYOUT in first error cycle", 32'd0, 32'(HREADYOUT));
      err_seen = 1'b1;
    end
    else if (HREADYOUT)
    begin
      check_value("OKAY response", 32'(e.err), 32'd0);
      if (!e.write)
        check_value("HRDATA", e.rdata, HRDATA);
      end_transfer(e);
    end
  endtask

  always @(negedge HCLK)
  begin
    if (HRESETn)
    begin
      // APB control moves only after a cycle with PCLKEN high
      if ((PSEL_0 | PSEL_1) != prev_sel || PENABLE_0 != prev_en)
        check_value("PCLKEN pacing", 32'd1, 32'(prev_pclken));
      prev_sel    = PSEL_0 | PSEL_1;
      prev_en     = PENABLE_0;
      prev_pclken = PCLKEN;
      if (n_checked == exp_q.size())
        check_value("PSEL while idle", 32'd0, 32'(PSEL_0 | PSEL_1));
      else
        compare_cycle();
    end
  end

  // --------------------
  // AHB master
  // --------------------
  task automatic set_mode(input string name, input logic pclk_rnd, input logic waits);
    while (n_checked != exp_q.size())
      @(posedge HCLK);
    test_name   = name;
    pclk_random = pclk_rnd;
    wait_states = waits;
  endtask

  task automatic run_xfer(input logic [31:0] addr, input logic write,
                          input ahb_pkg::hsize_t size, input logic [3:0] hprot,
                          input logic sw, input logic [31:0] wdata);
    xfer_exp_t e;
    while (n_checked != exp_q.size())
      @(posedge HCLK);
    e = ref_model(addr, write, size, hprot, sw, wdata);
    @(posedge HCLK);
    HSEL        <= 1'b1;
    HTRANS      <= 2'b10;  // NONSEQ
    HADDR       <= addr;
    HWRITE      <= write;
    HSIZE       <= size;
    HPROT       <= hprot;
    addr_switch <= sw;
    @(posedge HCLK);       // Bridge idle, so taken here
    exp_q.push_back(e);
    HSEL   <= 1'b0;
    HTRANS <= 2'b00;
    HWDATA <= wdata;       // Data phase
  endtask

  function automatic logic [31:0] rand_addr(input ahb_pkg::hsize_t size);
    logic [31:0] a;
    a = $urandom;
    if (size == ahb_pkg::hsize_half)
      a[0] = 1'b0;
    else if (size == ahb_pkg::hsize_word)
      a[1:0] = 2'b00;
    return a;
  endfunction

  task automatic random_xfer(input logic write);
    ahb_pkg::hsize_t size;
    size = ahb_pkg::hsize_t'(3'($urandom_range(0, 2)));
    run_xfer(rand_addr(size), write, size, 4'($urandom), 1'($urandom), $urandom);
  endtask

  initial
  begin
    void'($urandom(82197));
    HRESETn     = 1'b0;
    HSEL        = 1'b0;
    HADDR       = '0;
    HTRANS      = 2'b00;
    HSIZE       = ahb_pkg::hsize_word;
    HPROT       = 4'b0011;
    HWRITE      = 1'b0;
    HWDATA      = '0;
    addr_switch = 1'b0;
    repeat (4) @(posedge HCLK);
    HRESETn <= 1'b1;
    @(negedge HCLK);
    check_value("PSEL_0", 32'd0, 32'(PSEL_0));
    check_value("PSEL_1", 32'd0, 32'(PSEL_1));
    check_value("PENABLE_0", 32'd0, 32'(PENABLE_0));
    check_value("PENABLE_1", 32'd0, 32'(PENABLE_1));
    check_value("HRESP", 32'd0, 32'(HRESP));
    check_value("HREADYOUT", 32'd1, 32'(HREADYOUT));

    // Every size and byte offset
    set_mode("write_lanes", 1'b0, 1'b0);
    for (i = 0; i < 4; i++)
      run_xfer(32'h0000_1000 + i, 1'b1, ahb_pkg::hsize_byte, 4'($urandom), 1'b0, $urandom);
    for (i = 0; i < 4; i += 2)
      run_xfer(32'h0000_1000 + i, 1'b1, ahb_pkg::hsize_half, 4'($urandom), 1'b0, $urandom);
    run_xfer(32'h0000_1000, 1'b1, ahb_pkg::hsize_word, 4'($urandom), 1'b0, $urandom);

    // Address bit, addr_switch and direction
    set_mode("port_steering", 1'b0, 1'b0);
    for (i = 0; i < 8; i++)
      run_xfer(32'h0000_2040 | (32'(i & 1) << PORT_SEL_BIT), i[2], ahb_pkg::hsize_word,
               4'($urandom), i[1], $urandom);

    set_mode("read_no_wait", 1'b0, 1'b0);
    repeat (8) random_xfer(1'b0);
    set_mode("read_wait_states", 1'b0, 1'b1);
    repeat (16) random_xfer(1'b0);

    // Reserved address on each port
    set_mode("slave_error", 1'b0, 1'b0);
    for (i = 0; i < 4; i++)
      run_xfer(rsv_addr(i[0]), i[1], ahb_pkg::hsize_word, 4'($urandom), i[0], $urandom);

    set_mode("random_pclken", 1'b1, 1'b1);
    repeat (24) random_xfer(1'($urandom));

    set_mode("drain", 1'b0, 1'b0);
    $display("Test completed successfully");
    $finish;
  end

  // Watchdog
  initial
  begin
    #((4 + N_XFER * XFER_BUDGET) * CLK_PERIOD);
    $display("Run timed out in %s with %0d transfers still open", test_name,
             exp_q.size() - n_checked);
    $display("Test failed");
    $fatal(1, "Watchdog expired");
  end

endmodule

// ==== vlog.f ====
src/ahb_pkg.sv
src/apb_pkg.sv
src/apb_if.sv
src/ahb_decode.sv
src/apb_execute.sv
src/ahb_result.sv
src/apb_port_steer.sv
src/ahb2apb_bridge.sv
testbench/tb_ahb2apb.sv
